// File: Bender.yml
package:
  name: pcs_rx

sources:
  - include_dirs:
      - src
    files:
      - src/pcs_pkg.sv
      - src/pcs_blk_if.sv
      - src/pcs_rx_slip.sv
      - src/pcs_sync_rx.sv
      - src/pcs_descramble.sv
      - src/pcs_rx_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/pcs_rx_tb.sv

// File: src/pcs_blk_if.sv
`timescale 1ns/1ps
`default_nettype none

// one block per clock between rx stages, no stall
interface pcs_blk_if
	import pcs_pkg::*;
();

	logic valid; // block present this cycle
	pcs_head_t head; // sync header, raw
	pcs_data_t data; // payload
	logic lock; // lock status tagged to this block

	modport src (
		output valid,
		output head,
		output data,
		output lock
	);

	modport snk (
		input valid,
		input head,
		input data,
		input lock
	);

endinterface

`default_nettype wire

// File: src/pcs_cfg.svh
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

// block geometry, 64b/66b
`define PCS_BLK_W 66 // header + payload
`define PCS_HEAD_W 2 // sync header
`define PCS_DATA_W 64 // scrambled payload

// descrambler, 1 + x^39 + x^58
`define PCS_SCR_W 58 // history depth

// block lock thresholds
`define PCS_SH_GOOD_N 64 // good headers to lock
`define PCS_SH_WIN_N 1024 // header window length
`define PCS_SH_BAD_N 65 // bad headers in window to drop lock

`endif

// File: src/pcs_descramble.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

// self sync descrambler, 1 + x^39 + x^58, payload only
module pcs_descramble
	import pcs_pkg::*;
(
	input logic clk_i,
	input logic nreset_i,

	pcs_blk_if.snk blk_i,

	output logic valid_o,
	output pcs_head_t head_o,
	output pcs_data_t data_o,
	output logic lock_o
);

	localparam int TAP = 39; // inner tap of the polynomial

	pcs_scr_t scr_q; // last 58 scrambled bits, newest at msb
	logic [`PCS_SCR_W+`PCS_DATA_W-1:0] ext; // history then payload, arrival order
	pcs_data_t plain;

	assign ext = {blk_i.data, scr_q};

	// out[n] = in[n] ^ in[n-39] ^ in[n-58]
	always_comb begin
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			plain[i] = ext[i+`PCS_SCR_W] ^ ext[i+`PCS_SCR_W-TAP] ^ ext[i];
		end
	end

	always_ff @(posedge clk_i) begin
		if (nreset_i) begin
			valid_o <= 1'b0;
			lock_o <= 1'b0;
		end else begin
			valid_o <= blk_i.valid;
			lock_o <= blk_i.lock;
		end
	end

	// history and payload, no reset
	always_ff @(posedge clk_i) begin
		if (blk_i.valid) begin
			scr_q <= ext[`PCS_SCR_W+`PCS_DATA_W-1:`PCS_DATA_W]; // keep scrambled bits
			head_o <= blk_i.head;
			data_o <= plain;
		end
	end

	// one block in, one block out, a cycle later
	a_valid_lat: assert property (@(posedge clk_i) disable iff (nreset_i)
		valid_o == $past(blk_i.valid));

endmodule

`default_nettype wire

// File: src/pcs_pkg.sv
`default_nettype none

`include "pcs_cfg.svh"

package pcs_pkg;

	// bit 0 is the first bit off the wire
	typedef logic [`PCS_BLK_W-1:0] pcs_blk_t; // block or raw serdes word
	typedef logic [`PCS_HEAD_W-1:0] pcs_head_t; // 01 or 10 when valid
	typedef logic [`PCS_DATA_W-1:0] pcs_data_t; // payload
	typedef logic [$clog2(`PCS_BLK_W)-1:0] pcs_off_t; // slip offset 0..65
	typedef logic [`PCS_SCR_W-1:0] pcs_scr_t; // descrambler history

	typedef logic [$clog2(`PCS_SH_WIN_N)-1:0] pcs_cnt_t; // sh_cnt
	typedef logic [$clog2(`PCS_SH_BAD_N)-1:0] pcs_nv_cnt_t; // sh_invalid_cnt

	// block lock fsm, fig 49-14 reduced
	typedef enum logic [1:0] {
		SYNC_INVALID, // no signal
		SYNC_TEST, // hunting for header alignment
		SYNC_LOCK // rx_block_lock
	} pcs_sync_state_e;

endpackage

`default_nettype wire

// File: src/pcs_rx_slip.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

// bit slip aligner, cuts 66b blocks out of the raw word stream
module pcs_rx_slip
	import pcs_pkg::*;
(
	input logic clk_i,
	input logic nreset_i,

	input logic valid_i, // signal_ok
	input pcs_blk_t word_i, // raw serdes word
	input logic slip_i, // slip one bit

	pcs_blk_if.src blk_o
);

	pcs_blk_t prev_q; // last raw word
	pcs_off_t off_q; // current cut position
	pcs_off_t off_next;

	logic [2*`PCS_BLK_W-1:0] win; // prev word first, then current
	pcs_blk_t cut;

	// slip applies to the block cut on this edge
	always_comb begin
		off_next = off_q;
		if (slip_i) begin
			if (off_q == pcs_off_t'(`PCS_BLK_W-1)) begin
				off_next = '0; // wrap 65 -> 0
			end else begin
				off_next = off_q + 1'b1;
			end
		end
	end

	assign win = {word_i, prev_q}; // older bits at lsb
	assign cut = win[off_next +: `PCS_BLK_W];

	always_ff @(posedge clk_i) begin
		if (nreset_i) begin
			off_q <= '0;
			blk_o.valid <= 1'b0;
		end else begin
			off_q <= off_next;
			blk_o.valid <= valid_i;
		end
	end

	// payload path, no reset
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			prev_q <= word_i;
		end
		blk_o.head <= cut[`PCS_HEAD_W-1:0]; // first two bits on the wire
		blk_o.data <= cut[`PCS_BLK_W-1:`PCS_HEAD_W];
	end

	assign blk_o.lock = 1'b0; // no lock known before the sync stage

	a_off_range: assert property (@(posedge clk_i) disable iff (nreset_i)
		off_q < pcs_off_t'(`PCS_BLK_W));

	// nothing leaves the aligner straight out of reset
	a_rst_quiet: assert property (@(posedge clk_i)
		nreset_i |=> !blk_o.valid);

endmodule

`default_nettype wire

// File: src/pcs_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

// 64b/66b pcs rx lane: aligner -> block lock -> descrambler
module pcs_rx_top
	import pcs_pkg::*;
(
	input logic clk,
	input logic nreset,

	// serdes side
	input logic valid_i, // signal_ok
	input pcs_blk_t word_i, // raw, unaligned

	// block side
	output logic blk_valid_o,
	output pcs_head_t head_o,
	output pcs_data_t data_o,
	output logic lock_o // rx_block_lock
);

	pcs_blk_if slip_blk (); // aligner -> lock
	pcs_blk_if sync_blk (); // lock -> descrambler

	logic slip; // lock stage asks for a one bit slip

	pcs_rx_slip u_slip (
		.clk_i (clk),
		.nreset_i(nreset),
		.valid_i (valid_i),
		.word_i (word_i),
		.slip_i (slip),
		.blk_o (slip_blk.src)
	);

	pcs_sync_rx u_sync (
		.clk_i (clk),
		.nreset_i(nreset),
		.blk_i (slip_blk.snk),
		.blk_o (sync_blk.src),
		.slip_o (slip)
	);

	pcs_descramble u_descr (
		.clk_i (clk),
		.nreset_i(nreset),
		.blk_i (sync_blk.snk),
		.valid_o (blk_valid_o),
		.head_o (head_o),
		.data_o (data_o),
		.lock_o (lock_o)
	);

endmodule

`default_nettype wire

// File: src/pcs_sync_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

// per lane block lock on the 2b sync header
// invalid -> test -> lock, slip request back to the aligner
module pcs_sync_rx
	import pcs_pkg::*;
(
	input logic clk_i,
	input logic nreset_i,

	pcs_blk_if.snk blk_i, // aligned blocks, valid is signal_ok
	pcs_blk_if.src blk_o, // same blocks + lock

	output logic slip_o // comb, to aligner
);

	pcs_sync_state_e state_q;
	pcs_sync_state_e state_next;

	pcs_cnt_t cnt_q; // sh_cnt
	pcs_cnt_t cnt_next;
	pcs_nv_cnt_t nv_cnt_q; // sh_invalid_cnt
	pcs_nv_cnt_t nv_cnt_next;

	logic [$bits(pcs_cnt_t):0] cnt_add; // extra bit marks window end
	pcs_nv_cnt_t nv_cnt_add;

	logic sh_v; // sh_valid
	logic in_test;
	logic in_lock;
	logic good_64; // 64_GOOD
	logic bad_65; // too many bad headers
	logic win_end; // 1024 headers seen
	logic cnt_clr; // RESET_CNT
	logic slip;

	assign sh_v = ^blk_i.head; // 01 or 10
	assign in_test = (state_q == SYNC_TEST);
	assign in_lock = (state_q == SYNC_LOCK);

	// good headers while testing, every header once locked
	assign cnt_add = {1'b0, cnt_q} + {{$bits(pcs_cnt_t){1'b0}}, sh_v | in_lock};
	assign nv_cnt_add = nv_cnt_q + {{($bits(pcs_nv_cnt_t)-1){1'b0}}, ~sh_v};

	assign good_64 = in_test & sh_v & (cnt_add == `PCS_SH_GOOD_N);
	assign bad_65 = in_lock & (nv_cnt_add == `PCS_SH_BAD_N);
	assign win_end = (cnt_add == `PCS_SH_WIN_N);

	assign slip = blk_i.valid & ((in_test & ~sh_v) // bad header while hunting
		| bad_65); // lock lost
	assign slip_o = slip;

	assign cnt_clr = ~blk_i.valid // signal not ok
		| (state_q == SYNC_INVALID) // fresh start in test
		| good_64
		| slip
		| win_end;

	assign cnt_next = cnt_clr ? '0 : pcs_cnt_t'(cnt_add);
	assign nv_cnt_next = cnt_clr ? '0 : nv_cnt_add;

	always_comb begin
		state_next = state_q;
		if (!blk_i.valid) begin
			state_next = SYNC_INVALID; // drop on signal loss
		end else begin
			case (state_q)
				SYNC_INVALID: begin
					state_next = SYNC_TEST; // signal back
				end
				SYNC_TEST: begin
					if (good_64) begin
						state_next = SYNC_LOCK;
					end
				end
				SYNC_LOCK: begin
					if (bad_65) begin
						state_next = SYNC_TEST; // slip and hunt again
					end
				end
				default: begin
					state_next = SYNC_INVALID;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (nreset_i) begin
			state_q <= SYNC_INVALID;
			cnt_q <= '0;
			nv_cnt_q <= '0;
			blk_o.valid <= 1'b0;
			blk_o.lock <= 1'b0;
		end else begin
			state_q <= state_next;
			cnt_q <= cnt_next;
			nv_cnt_q <= nv_cnt_next;
			blk_o.valid <= blk_i.valid;
			blk_o.lock <= (state_next == SYNC_LOCK); // goes with this block
		end
	end

	// block payload, no reset
	always_ff @(posedge clk_i) begin
		blk_o.head <= blk_i.head;
		blk_o.data <= blk_i.data;
	end

	a_state_legal: assert property (@(posedge clk_i) disable iff (nreset_i)
		state_q inside {SYNC_INVALID, SYNC_TEST, SYNC_LOCK});

	a_no_slip_invalid: assert property (@(posedge clk_i) disable iff (nreset_i)
		(state_q == SYNC_INVALID) |-> !slip_o);

	// lock can only be won from the test state
	a_lock_from_test: assert property (@(posedge clk_i) disable iff (nreset_i)
		$rose(blk_o.lock) |-> ($past(state_q) == SYNC_TEST));

endmodule

`default_nettype wire

// File: verif/pcs_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module pcs_rx_tb
	import pcs_pkg::*;
();

	localparam int N_ROWS = 4;
	localparam int N_CHK = 24; // locked blocks checked per phase
	localparam int DROP_N = 6; // cycles of signal loss
	localparam int MAX_CYC = N_ROWS * 66 * 70 + 1200; // slip-and-lock budget per row

	typedef struct packed {
		logic [6:0] off; // start bit offset of the stream
		logic [6:0] n_bad; // invalid headers injected after lock
		logic drop; // signal loss after lock
		logic exp_lock; // lock_o after injection and drop
	} row_t;

	logic clk;
	logic nreset;
	logic valid_i;
	pcs_blk_t word_i;
	logic blk_valid_o;
	pcs_head_t head_o;
	pcs_data_t data_o;
	logic lock_o;

	row_t rows [0:N_ROWS-1];
	integer seed; // $random state
	int cyc_cnt = 0;

	pcs_scr_t scr_sr; // scrambler model, [0] newest bit
	bit bits_q[$]; // serial line, front goes out first
	pcs_data_t plain_q[$]; // plaintext per block, sending order
	pcs_head_t head_q[$]; // header actually sent
	bit inj_q[$]; // block carries a forced bad header

	int inj_from = 0; // first block index to corrupt
	int inj_left = 0;
	int search_lo = 0; // oldest block of the current row
	bit tracking = 1'b0; // output matched to the stream
	int trk_idx = 0; // stream index of the current output block
	int chk_cnt = 0; // locked blocks checked since last reset of count

	pcs_rx_top dut0 (
		.clk (clk),
		.nreset (nreset),
		.valid_i (valid_i),
		.word_i (word_i),
		.blk_valid_o(blk_valid_o),
		.head_o (head_o),
		.data_o (data_o),
		.lock_o (lock_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns
	end

	always @(posedge clk) begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt >= MAX_CYC) begin
			$display("timeout: lock and payload checks not done after %0d cycles",
				MAX_CYC);
			$display("Regression failed");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	task automatic report_error(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Regression failed");
		$fatal(1, "testbench error");
	endtask

	task automatic check_lock(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %b expected %b", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "lock compare");
		end
	endtask

	task automatic check_head(input pcs_head_t got, input pcs_head_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %b expected %b", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "header compare");
		end
	endtask

	task automatic check_data(input pcs_data_t got, input pcs_data_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "payload compare");
		end
	endtask

	// s[n] = p[n] ^ s[n-39] ^ s[n-58], payload bits only
	task automatic scramble(input pcs_data_t p, output pcs_data_t s);
		logic b;
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			b = p[i] ^ scr_sr[38] ^ scr_sr[57];
			scr_sr = {scr_sr[56:0], b};
			s[i] = b;
		end
	endtask

	// one new block onto the line, header bit 0 first
	task automatic gen_block();
		pcs_data_t plain;
		pcs_data_t scr;
		pcs_head_t head;
		logic [31:0] rnd;
		bit inj;
		plain = {$random(seed), $random(seed)};
		rnd = $random(seed);
		head = rnd[0] ? 2'b10 : 2'b01;
		inj = 1'b0;
		if (inj_left > 0 && plain_q.size() >= inj_from) begin
			head = rnd[1] ? 2'b11 : 2'b00; // invalid sync header
			inj = 1'b1;
			inj_left--;
		end
		scramble(plain, scr);
		bits_q.push_back(head[0]);
		bits_q.push_back(head[1]);
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			bits_q.push_back(scr[i]);
		end
		plain_q.push_back(plain);
		head_q.push_back(head);
		inj_q.push_back(inj);
	endtask

	// newest first, within this row only
	function automatic int find_block(input pcs_data_t d, input pcs_head_t h);
		int j;
		for (j = plain_q.size() - 1; j >= search_lo; j--) begin
			if (plain_q[j] === d && head_q[j] === h) begin
				return j;
			end
		end
		return -1;
	endfunction

	task automatic watch_output();
		int j;
		if (blk_valid_o === 1'b1 && lock_o === 1'b1) begin
			if (!tracking) begin
				j = find_block(data_o, head_o); // first locked block sets position
				if (j < 0) begin
					report_error("first locked block matches no block sent in this row");
				end else begin
					trk_idx = j;
					tracking = 1'b1;
				end
			end else begin
				trk_idx++;
				if (!inj_q[trk_idx]) begin
					check_head(head_o, head_q[trk_idx],
						$sformatf("header of block %0d", trk_idx));
				end
				if (!inj_q[trk_idx] && !inj_q[trk_idx-1]) begin
					check_data(data_o, plain_q[trk_idx],
						$sformatf("payload of block %0d", trk_idx));
				end
				chk_cnt++;
			end
		end else begin
			tracking = 1'b0; // lost lock or signal
			chk_cnt = 0;
		end
	endtask

	// sample at the falling edge, then drive the next raw word
	task automatic step(input logic v);
		pcs_blk_t w;
		@(negedge clk);
		watch_output();
		while (bits_q.size() < `PCS_BLK_W) begin
			gen_block();
		end
		for (int i = 0; i < `PCS_BLK_W; i++) begin
			w[i] = bits_q.pop_front();
		end
		valid_i = v;
		word_i = w;
	endtask

	task automatic wait_locked(input int n);
		chk_cnt = 0;
		while (chk_cnt < n) begin
			step(1'b1);
		end
	endtask

	// line words still pass, signal_ok is low
	task automatic drop_signal();
		repeat (DROP_N) step(1'b0);
		check_lock(blk_valid_o, 1'b0, "blk_valid_o during signal loss");
		check_lock(lock_o, 1'b0, "lock_o during signal loss");
	endtask

	task automatic begin_row(input int off);
		logic [31:0] rnd;
		drop_signal();
		bits_q.delete(); // new stream, new block boundary
		for (int i = 0; i < off; i++) begin
			rnd = $random(seed);
			bits_q.push_back(rnd[0]); // filler ahead of the first block
		end
		search_lo = plain_q.size();
	endtask

	task automatic inject_headers(input int n);
		int last;
		inj_from = plain_q.size() + 2;
		inj_left = n;
		last = inj_from + n - 1;
		while (plain_q.size() < last + 5) begin
			step(1'b1); // bad block and two more fully on the line
		end
		repeat (4) step(1'b1); // three stage pipeline plus cut
	endtask

	initial begin : main_seq
		row_t row;
		rows[0] = '{off: 7'd0, n_bad: 7'd0, drop: 1'b0, exp_lock: 1'b1};
		rows[1] = '{off: 7'd1, n_bad: 7'd16, drop: 1'b0, exp_lock: 1'b1};
		rows[2] = '{off: 7'd33, n_bad: 7'd65, drop: 1'b0, exp_lock: 1'b0};
		rows[3] = '{off: 7'd65, n_bad: 7'd0, drop: 1'b1, exp_lock: 1'b0};
		seed = 32'hdecc_11d0;
		scr_sr = pcs_scr_t'({$random(seed), $random(seed)});
		nreset = 1'b1;
		valid_i = 1'b0;
		word_i = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		nreset = 1'b0;

		// quiet out of reset while the line is down
		for (int k = 0; k < 8; k++) begin
			step(1'b0);
			check_lock(blk_valid_o, 1'b0, "blk_valid_o after reset");
			check_lock(lock_o, 1'b0, "lock_o after reset");
		end

		for (int r = 0; r < N_ROWS; r++) begin
			row = rows[r];
			begin_row(int'(row.off));
			wait_locked(N_CHK); // hunt, lock, payload ok
			if (row.n_bad != 0) begin
				inject_headers(int'(row.n_bad));
				check_lock(lock_o, row.exp_lock,
					$sformatf("lock_o after disturbance, row %0d", r));
			end
			if (row.drop) begin
				drop_signal(); // lock_o must be low here
			end
			wait_locked(N_CHK); // relock where lost, payload again
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/pcs_pkg.sv
src/pcs_blk_if.sv
src/pcs_rx_slip.sv
src/pcs_sync_rx.sv
src/pcs_descramble.sv
src/pcs_rx_top.sv
verif/pcs_rx_tb.sv
